// ==== src.f ====
rtl/xform_pkg.sv
rtl/fp16_mul.sv
rtl/fp16_add.sv
rtl/product_stage.sv
rtl/operand_delay.sv
rtl/sum_stage.sv
rtl/xform_top.sv
tb/xform_assertions.sv
tb/xform_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the xform testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir

verilator --binary --assert --top-module xform_tb -f src.f -Mdir obj_dir -o xform_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/xform_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// ==== tb/xform_tb.sv ====
`default_nettype none

module xform_tb import xform_pkg::*; ();

    localparam int RESET_CYCLES   = 10;
    localparam int BURST_OPS      = 50;
    localparam int GAP_OPS        = 40;
    // idle, two singles, burst, gapped run, cancel; each with its drain
    localparam int TEST_CYCLES    = 8 + 12 + 12 + (BURST_OPS + 12) + (GAP_OPS * 4 + 12) + 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + XFORM_LATENCY + 50;

    logic       clk;
    logic       rst_n;
    logic       valid_in;
    xform_req_t req;
    logic       valid_out;
    vec3_t      result;

    vec3_t exp_q [$];                                 // expected results, oldest first
    int    due_q [$];                                 // cycle each one is due
    int    ai [3];                                    // integer lanes of next request
    int    bi [3];
    int    ci [3];
    int    seed      = 32'h9973_1599;
    int    cycle     = 0;
    int    errors    = 0;
    int    err_mark  = 0;                             // errors at start of current test
    int    n_checked = 0;
    int    tests_ok  = 0;
    int    tests_bad = 0;

    xform_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .req       (req),
        .valid_out (valid_out),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                        // period 4
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // exact integer -> binary16, small magnitudes only
    function automatic fp16_t to_fp16(input int v);
        fp16_t f;
        int    mag;
        int    msb;
        f   = '0;                                     // zero is always +0
        mag = (v < 0) ? -v : v;
        msb = 0;
        if (mag != 0) begin
            for (int i = 0; i < 11; i++) begin
                if (mag >= (1 << i)) begin
                    msb = i;
                end
            end
            f.sign     = (v < 0);
            f.exponent = 5'(msb + FP16_EXP_BIAS);
            f.mantissa = 10'(mag << (10 - msb));      // hidden bit falls off the top
        end
        return f;
    endfunction

    function automatic vec3_t to_vec(input int vx, input int vy, input int vz);
        vec3_t v;
        v.x = to_fp16(vx);
        v.y = to_fp16(vy);
        v.z = to_fp16(vz);
        return v;
    endfunction

    task automatic report_mismatch(input string name, input fp16_t exp_v, input fp16_t got);
        errors++;
        $display("[FAIL] %s expected 0x%h got 0x%h at cycle %0d", name, exp_v, got, cycle);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("error at cycle %0d: %s", cycle, what);
    endtask

    task automatic fill_random();
        for (int i = 0; i < 3; i++) begin
            ai[i] = $random(seed) % 9;                // -8 .. 8
            bi[i] = $random(seed) % 9;
            ci[i] = $random(seed) % 9;
        end
    endtask

    // one request, expected value from plain integer arithmetic
    task automatic send(input xform_op_e op);
        xform_req_t r;
        vec3_t      e;
        r.op = op;
        r.a  = to_vec(ai[0], ai[1], ai[2]);
        r.b  = to_vec(bi[0], bi[1], bi[2]);
        r.c  = to_vec(ci[0], ci[1], ci[2]);
        if (op == op_dot) begin
            e = to_vec(ai[0] * bi[0] + ai[1] * bi[1] + ai[2] * bi[2], 0, 0);
        end else begin
            e = to_vec(ai[0] * bi[0] + ci[0], ai[1] * bi[1] + ci[1], ai[2] * bi[2] + ci[2]);
        end
        @(posedge clk);
        #1;
        req      = r;
        valid_in = 1'b1;
        exp_q.push_back(e);
        due_q.push_back(cycle + XFORM_LATENCY);      // captured next edge
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    task automatic drain();
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);                    // room for a stray valid_out
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(negedge clk) begin : check_outputs
        vec3_t exp_v;
        int    due;
        if (!rst_n) begin
            assert (!valid_out) else report_problem("valid_out high during reset");
        end else if (valid_out) begin
            assert (!$isunknown(result)) else report_problem("result has unknown bits");
            if (exp_q.size() == 0) begin
                report_problem("valid_out high with no operation in flight");
            end else begin
                exp_v = exp_q.pop_front();
                due   = due_q.pop_front();
                n_checked++;
                assert (cycle == due) else report_problem("result off the pipeline latency");
                assert (result.x == exp_v.x) else report_mismatch("result.x", exp_v.x, result.x);
                assert (result.y == exp_v.y) else report_mismatch("result.y", exp_v.y, result.y);
                assert (result.z == exp_v.z) else report_mismatch("result.z", exp_v.z, result.z);
            end
        end
    end

    initial begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles, %0d results outstanding", cycle, exp_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        xform_op_e op;
        int        gap;
        rst_n    = 1'b0;
        valid_in = 1'b0;
        req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (8) @(posedge clk);                    // reset and idle checked by monitor
        end_test("idle_after_reset");

        ai = '{3, -2, 5};
        bi = '{4, 7, -8};
        ci = '{-6, 1, 8};
        send(op_affine);
        drain();
        end_test("affine_single");

        ai = '{-5, 8, 2};
        bi = '{3, 6, -7};
        ci = '{1, 1, 1};                              // ignored by dot
        send(op_dot);
        drain();
        end_test("dot_single");

        for (int i = 0; i < BURST_OPS; i++) begin
            fill_random();
            op = ($random(seed) & 1) ? op_dot : op_affine;
            send(op);
        end
        drain();
        end_test("burst_mixed");

        for (int i = 0; i < GAP_OPS; i++) begin
            fill_random();
            op  = ($random(seed) & 1) ? op_dot : op_affine;
            gap = $random(seed) & 3;
            send(op);
            repeat (gap) idle();
        end
        drain();
        end_test("gapped_valid");

        ai = '{3, -2, 5};                             // product plus its negation
        bi = '{4, 5, -1};
        ci = '{-12, 10, 5};
        send(op_affine);
        ai = '{2, 3, 1};                              // 6 - 6 + 0
        bi = '{3, -2, 0};
        send(op_dot);
        ai = '{-2, 2, 0};                             // z product is -0
        bi = '{3, 3, -7};
        send(op_dot);
        drain();
        end_test("cancel_to_zero");

        $display("summary: %0d tests ok, %0d with errors, %0d results checked in %0d cycles",
                 tests_ok, tests_bad, n_checked, cycle);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/xform_assertions.sv ====
`default_nettype none

module xform_assertions import xform_pkg::*; (
    input wire        clk,
    input wire        rst_n,
    input wire        valid_in,
    input wire        valid_out,
    input wire vec3_t result
);
    // strobe leaves exactly one pipeline depth after it enters
    property p_latency;
        @(posedge clk) disable iff (!rst_n)
            valid_out == $past(valid_in, XFORM_LATENCY);
    endproperty

    property p_reset_quiet;
        @(posedge clk) !rst_n |-> !valid_out;         // valid regs cleared in reset
    endproperty

    property p_result_known;
        @(posedge clk) disable iff (!rst_n)
            valid_out |-> !$isunknown(result);
    endproperty

    a_latency: assert property (p_latency)
        else $error("valid_out does not follow valid_in by %0d cycles", XFORM_LATENCY);
    a_reset_quiet: assert property (p_reset_quiet)
        else $error("valid_out high while rst_n is low");
    a_result_known: assert property (p_result_known)
        else $error("result has unknown bits while valid_out is high");

endmodule

bind xform_top xform_assertions u_assertions (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .result    (result)
);

`default_nettype wire

// ==== rtl/xform_top.sv ====
`default_nettype none

module xform_top import xform_pkg::*; (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             valid_in,
    input  wire xform_req_t req,
    output logic            valid_out,
    output vec3_t           result
);
    vec3_t     prod;                                  // a * b per lane
    logic      prod_valid;
    vec3_t     addend;                                // c, delayed to meet prod
    xform_op_e op_d;

    product_stage u_product (
        .clk        (clk),
        .rst_n      (rst_n),
        .valid_in   (valid_in),
        .a          (req.a),
        .b          (req.b),
        .prod       (prod),
        .prod_valid (prod_valid)
    );

    operand_delay u_delay (
        .clk    (clk),
        .c      (req.c),
        .op     (req.op),
        .addend (addend),
        .op_d   (op_d)
    );

    sum_stage u_sum (
        .clk        (clk),
        .rst_n      (rst_n),
        .prod_valid (prod_valid),
        .prod       (prod),
        .addend     (addend),
        .op_d       (op_d),
        .result     (result),
        .valid_out  (valid_out)
    );

endmodule

`default_nettype wire

// ==== rtl/sum_stage.sv ====
`default_nettype none

module sum_stage import xform_pkg::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            prod_valid,
    input  wire vec3_t     prod,
    input  wire vec3_t     addend,
    input  wire xform_op_e op_d,
    output vec3_t          result,
    output logic           valid_out
);
    fp16_t                   b_x1;                    // x addend, level one
    vec3_t                   lvl1;                    // level one sums
    fp16_t                   a_y2;
    fp16_t                   b_x2;
    fp16_t                   s_x2;
    fp16_t                   s_y2;
    fp16_t                   pz_sr [ADD_STAGES];      // z product for dot
    fp16_t                   z_sr  [ADD_STAGES];      // z sum retimed past level two
    xform_op_e               op_sr [ADD_STAGES];
    logic [2*ADD_STAGES-1:0] vld_sr;

    // dot folds y product into x lane, affine adds c
    assign b_x1 = (op_d == op_dot) ? prod.y : addend.x;

    fp16_add u_add_x1 (.clk(clk), .a(prod.x), .b(b_x1),     .s(lvl1.x));
    fp16_add u_add_y1 (.clk(clk), .a(prod.y), .b(addend.y), .s(lvl1.y));
    fp16_add u_add_z1 (.clk(clk), .a(prod.z), .b(addend.z), .s(lvl1.z));

    always_ff @(posedge clk) begin
        pz_sr[0] <= prod.z;
        op_sr[0] <= op_d;
        z_sr[0]  <= (op_sr[ADD_STAGES-1] == op_dot) ? FP16_ZERO : lvl1.z;  // dot zeroes z
        for (int i = 1; i < ADD_STAGES; i++) begin
            pz_sr[i] <= pz_sr[i-1];
            op_sr[i] <= op_sr[i-1];
            z_sr[i]  <= z_sr[i-1];
        end
    end

    // level two, affine passes sums through a +0 add
    assign b_x2 = (op_sr[ADD_STAGES-1] == op_dot) ? pz_sr[ADD_STAGES-1] : FP16_ZERO;
    assign a_y2 = (op_sr[ADD_STAGES-1] == op_dot) ? FP16_ZERO : lvl1.y;  // 0 + 0 -> y = +0

    fp16_add u_add_x2 (.clk(clk), .a(lvl1.x), .b(b_x2),      .s(s_x2));
    fp16_add u_add_y2 (.clk(clk), .a(a_y2),   .b(FP16_ZERO), .s(s_y2));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[2*ADD_STAGES-2:0], prod_valid};  // both adder levels
        end
    end

    assign result.x  = s_x2;
    assign result.y  = s_y2;
    assign result.z  = z_sr[ADD_STAGES-1];
    assign valid_out = vld_sr[2*ADD_STAGES-1];

endmodule

`default_nettype wire

// ==== rtl/operand_delay.sv ====
`default_nettype none

module operand_delay import xform_pkg::*; (
    input  wire            clk,
    input  wire vec3_t     c,
    input  wire xform_op_e op,
    output vec3_t          addend,
    output xform_op_e      op_d
);
    vec3_t     c_sr  [MUL_STAGES];                   // addend rides with the products
    xform_op_e op_sr [MUL_STAGES];

    always_ff @(posedge clk) begin
        c_sr[0]  <= c;
        op_sr[0] <= op;
        for (int i = 1; i < MUL_STAGES; i++) begin
            c_sr[i]  <= c_sr[i-1];
            op_sr[i] <= op_sr[i-1];
        end
    end

    assign addend = c_sr[MUL_STAGES-1];              // lines up with prod
    assign op_d   = op_sr[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== rtl/product_stage.sv ====
`default_nettype none

module product_stage import xform_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        valid_in,
    input  wire vec3_t a,
    input  wire vec3_t b,
    output vec3_t      prod,
    output logic       prod_valid
);
    logic [MUL_STAGES-1:0] vld_sr;                   // valid beside the multipliers

    fp16_mul u_mul_x (
        .clk (clk),
        .a   (a.x),
        .b   (b.x),
        .p   (prod.x)
    );

    fp16_mul u_mul_y (
        .clk (clk),
        .a   (a.y),
        .b   (b.y),
        .p   (prod.y)
    );

    fp16_mul u_mul_z (
        .clk (clk),
        .a   (a.z),
        .b   (b.z),
        .p   (prod.z)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[MUL_STAGES-2:0], valid_in};
        end
    end

    assign prod_valid = vld_sr[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== rtl/fp16_add.sv ====
`default_nettype none

module fp16_add import xform_pkg::*; (
    input  wire        clk,
    input  wire fp16_t a,
    input  wire fp16_t b,
    output fp16_t      s
);
    // stage 1 comb
    logic [14:0] mag_a;                              // {exp, man} or 0 when flushed
    logic [14:0] mag_b;
    logic        swap;
    fp16_t       big;
    fp16_t       lesser;
    logic [4:0]  exp_diff;
    logic [13:0] man_big;                            // hidden + 10 man + 3 guard
    logic [13:0] man_small;

    // stage 1 regs
    logic        s1_sign;
    logic        s1_sub;
    logic [4:0]  s1_exp;
    logic [13:0] s1_big;
    logic [13:0] s1_small;

    // stage 2 comb
    logic [14:0]       sum;
    logic [3:0]        lz;
    logic [14:0]       norm;
    logic signed [6:0] exp_res;
    fp16_t             s_next;

    function automatic logic [3:0] lzc15(input logic [14:0] v);
        logic [3:0] n;
        logic       found;
        n     = '0;
        found = 1'b0;
        for (int i = 14; i >= 0; i--) begin
            if (!found) begin
                if (v[i]) begin
                    found = 1'b1;
                end else begin
                    n = n + 4'd1;
                end
            end
        end
        return n;
    endfunction

    always_comb begin
        mag_a     = (a.exponent == '0) ? '0 : {a.exponent, a.mantissa};  // ftz
        mag_b     = (b.exponent == '0) ? '0 : {b.exponent, b.mantissa};
        swap      = mag_b > mag_a;                   // larger magnitude goes first
        big       = swap ? b : a;
        lesser    = swap ? a : b;
        exp_diff  = big.exponent - lesser.exponent;
        man_big   = (big.exponent == '0) ? '0 : {1'b1, big.mantissa, 3'b000};
        // alignment shift drops bits past the guard
        man_small = (lesser.exponent == '0) ? '0 :
                    ({1'b1, lesser.mantissa, 3'b000} >> exp_diff);
    end

    always_ff @(posedge clk) begin
        s1_sign  <= big.sign;                        // result takes sign of larger
        s1_sub   <= a.sign ^ b.sign;                 // effective subtract
        s1_exp   <= big.exponent;
        s1_big   <= man_big;
        s1_small <= man_small;
    end

    always_comb begin
        sum     = s1_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
                         : ({1'b0, s1_big} + {1'b0, s1_small});
        lz      = lzc15(sum);
        norm    = sum << lz;                         // msb lands on bit 14
        exp_res = 7'(s1_exp) + 7'd1 - 7'(lz);        // carry out -> lz 0 -> exp+1
        if (sum == '0) begin
            s_next = FP16_ZERO;                      // exact cancel gives +0
        end else if (exp_res <= 0) begin
            s_next.sign     = s1_sign;               // underflow flush
            s_next.exponent = '0;
            s_next.mantissa = '0;
        end else if (exp_res > $signed({2'b00, FP16_EXP_MAX})) begin
            s_next.sign     = s1_sign;               // overflow saturate
            s_next.exponent = FP16_EXP_MAX;
            s_next.mantissa = '1;
        end else begin
            s_next.sign     = s1_sign;
            s_next.exponent = exp_res[FP16_EXP_W-1:0];
            s_next.mantissa = norm[13:4];            // truncate guard bits
        end
    end

    always_ff @(posedge clk) begin
        s <= s_next;
    end

endmodule

`default_nettype wire

// ==== rtl/fp16_mul.sv ====
`default_nettype none

module fp16_mul import xform_pkg::*; (
    input  wire        clk,
    input  wire fp16_t a,
    input  wire fp16_t b,
    output fp16_t      p
);
    // stage 1 regs
    logic        s1_sign;
    logic        s1_zero;                        // either operand zero or subnormal
    logic [5:0]  s1_exp_sum;                     // raw biased sum in 0..60
    logic [21:0] s1_prod;                        // 11b x 11b significands

    // stage 2 comb
    logic signed [7:0]     exp_adj;
    logic [FP16_MAN_W-1:0] man_norm;
    fp16_t                 p_next;

    always_ff @(posedge clk) begin
        s1_sign    <= a.sign ^ b.sign;
        s1_zero    <= (a.exponent == '0) || (b.exponent == '0);  // ftz on inputs
        s1_exp_sum <= {1'b0, a.exponent} + {1'b0, b.exponent};
        s1_prod    <= 22'({1'b1, a.mantissa}) * 22'({1'b1, b.mantissa});  // hidden bits restored
    end

    always_comb begin
        // product in [1,4) -> one bit of normalization at most
        exp_adj  = 8'(s1_exp_sum) - 8'(FP16_EXP_BIAS) + 8'(s1_prod[21]);
        man_norm = s1_prod[21] ? s1_prod[20:11] : s1_prod[19:10];  // truncation is rtz
        if (s1_zero || exp_adj <= 0) begin
            p_next.sign     = s1_sign;                // signed zero
            p_next.exponent = '0;
            p_next.mantissa = '0;
        end else if (exp_adj > $signed({3'b000, FP16_EXP_MAX})) begin
            p_next.sign     = s1_sign;                // saturate to max finite
            p_next.exponent = FP16_EXP_MAX;
            p_next.mantissa = '1;
        end else begin
            p_next.sign     = s1_sign;
            p_next.exponent = exp_adj[FP16_EXP_W-1:0];
            p_next.mantissa = man_norm;
        end
    end

    always_ff @(posedge clk) begin
        p <= p_next;                                  // stage 2 output reg
    end

endmodule

`default_nettype wire

// ==== rtl/xform_pkg.sv ====
`default_nettype none

package xform_pkg;

    // binary16 field widths
    localparam int FP16_EXP_W = 5;
    localparam int FP16_MAN_W = 10;

    localparam int FP16_EXP_BIAS = 15;                            // ieee half bias
    localparam logic [FP16_EXP_W-1:0] FP16_EXP_MAX = 5'd30;      // largest finite exp field

    // pipeline depths
    localparam int MUL_STAGES    = 2;
    localparam int ADD_STAGES    = 2;
    localparam int XFORM_LATENCY = MUL_STAGES + 2 * ADD_STAGES;  // 6 cycles

    typedef struct packed {
        logic                  sign;
        logic [FP16_EXP_W-1:0] exponent;
        logic [FP16_MAN_W-1:0] mantissa;
    } fp16_t;                                                     // 16 bits

    localparam fp16_t FP16_ZERO = '0;                             // +0

    typedef struct packed {
        fp16_t x;
        fp16_t y;
        fp16_t z;
    } vec3_t;                                                     // 48 bits

    typedef enum logic {
        op_affine = 1'b0,                                         // a * b + c per lane
        op_dot    = 1'b1                                          // sum of a * b into x
    } xform_op_e;

    typedef struct packed {
        xform_op_e op;
        vec3_t     a;
        vec3_t     b;
        vec3_t     c;
    } xform_req_t;                                                // 145 bits

endpackage

`default_nettype wire
